// ==== Bender.yml ====
package:
  name: spi_bridge

sources:
  # package and interface first
  - common/spi_bridge_pkg.sv
  - common/reg_wr_if.sv
  # blocks
  - spi_frontend/spi_frame_shifter.sv
  - source/ctrl_reg_bank.sv
  - source/periph_spi_router.sv
  - source/status_blinker.sv
  # top level
  - source/spi_bridge_top.sv

  - target: test
    files:
      - tests/spi_bridge_tb.sv

// ==== common/reg_wr_if.sv ====
`timescale 1ns/1ps

// one register write, four-phase req/ack
interface reg_wr_if;

  logic                               req;
  logic                               ack;
  logic [spi_bridge_pkg::ADDR_W-1:0]  addr;   // held until ack drops
  logic [spi_bridge_pkg::VAL_W-1:0]   val;    // {clear nibble, set nibble}

  // frame shifter side
  modport src (
    output req,
    output addr,
    output val,
    input  ack
  );

  // register bank side
  modport dst (
    input  req,
    input  addr,
    input  val,
    output ack
  );

endinterface

// ==== common/spi_bridge_pkg.sv ====
package spi_bridge_pkg;

  ////////////////////
  // frame layout

  localparam int FRAME_W = 16;                 // bits per bridge frame
  localparam int ADDR_W  = 8;                  // high byte of the frame
  localparam int VAL_W   = FRAME_W - ADDR_W;   // clear nibble : set nibble
  localparam int REG_W   = 4;                  // one control register

  ////////////////////
  // peripherals

  // index 0 adc, 1 dac, 2 flash
  localparam int NUM_PERIPH = 3;

  ////////////////////
  // register map

  localparam logic [ADDR_W-1:0] ADDR_LED      = 8'd7;
  localparam logic [ADDR_W-1:0] ADDR_MUX      = 8'd8;
  localparam logic [ADDR_W-1:0] ADDR_DAC      = 8'd9;
  localparam logic [ADDR_W-1:0] ADDR_RAILS    = 8'd10;
  localparam logic [ADDR_W-1:0] ADDR_SOFT_RST = 8'd11;   // zeroes all four regs

  // led register bit that takes the leds off the blinker
  localparam int LED_MANUAL_BIT = 3;

endpackage

// ==== source/ctrl_reg_bank.sv ====
`timescale 1ns/1ps

module ctrl_reg_bank (
  input  logic                               clk,
  input  logic                               rst_n,
  output logic [spi_bridge_pkg::REG_W-1:0]   reg_led,
  output logic [spi_bridge_pkg::REG_W-1:0]   reg_mux,
  output logic [spi_bridge_pkg::REG_W-1:0]   reg_dac,
  output logic [spi_bridge_pkg::REG_W-1:0]   reg_rails,
  output logic [spi_bridge_pkg::FRAME_W-1:0] readback,
  reg_wr_if.dst                              wr
);

  localparam int RW = spi_bridge_pkg::REG_W;

  logic write_go;   // new request, not yet acked

  // set first, then clear; clear wins on overlap
  function automatic logic [RW-1:0] set_clr(
    input logic [RW-1:0]                     cur,
    input logic [spi_bridge_pkg::VAL_W-1:0]  val
  );
    logic [RW-1:0] set_bits;
    logic [RW-1:0] clr_bits;
    set_bits = val[RW-1:0];        // low nibble
    clr_bits = val[2*RW-1:RW];     // high nibble
    return (cur | set_bits) & ~clr_bits;
  endfunction

  assign write_go = wr.req && !wr.ack;

  ////////////////////
  // register update

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      reg_led   <= '0;
      reg_mux   <= '0;
      reg_dac   <= '0;
      reg_rails <= '0;
    end
    else if (write_go)
    begin
      case (wr.addr)
        spi_bridge_pkg::ADDR_LED:   reg_led   <= set_clr(reg_led, wr.val);
        spi_bridge_pkg::ADDR_MUX:   reg_mux   <= set_clr(reg_mux, wr.val);
        spi_bridge_pkg::ADDR_DAC:   reg_dac   <= set_clr(reg_dac, wr.val);
        spi_bridge_pkg::ADDR_RAILS: reg_rails <= set_clr(reg_rails, wr.val);
        spi_bridge_pkg::ADDR_SOFT_RST:
        begin
          reg_led   <= '0;
          reg_mux   <= '0;
          reg_dac   <= '0;
          reg_rails <= '0;
        end
        default: ;    // unknown address, still acked below
      endcase
    end
  end

  ////////////////////
  // ack side of handshake

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      wr.ack <= 1'b0;
    else if (write_go)
      wr.ack <= 1'b1;          // same edge as the update
    else if (!wr.req && wr.ack)
      wr.ack <= 1'b0;          // req gone, close out
  end

  // shifted out msb first, led first
  assign readback = {reg_led, reg_mux, reg_dac, reg_rails};

endmodule

// ==== source/periph_spi_router.sv ====
`timescale 1ns/1ps

module periph_spi_router (
  input  logic                                  cs_n,
  input  logic                                  special_n,
  input  logic [spi_bridge_pkg::REG_W-1:0]      reg_mux,
  input  logic [spi_bridge_pkg::NUM_PERIPH-1:0] periph_miso,
  input  logic                                  bridge_miso,
  output logic [spi_bridge_pkg::NUM_PERIPH-1:0] periph_cs_n,
  output logic                                  miso
);

  localparam int NP = spi_bridge_pkg::NUM_PERIPH;

  logic [NP-1:0] sel;    // mux bits that map to a peripheral

  // only the low bits of the mux register route anything
  assign sel = reg_mux[NP-1:0];

  ////////////////////
  // cs and miso select

  always_comb
  begin
    if (!special_n)
    begin
      // bridge frame, keep every peripheral off the bus
      periph_cs_n = '1;
      miso        = bridge_miso;
    end
    else
    begin
      // selected peripherals follow the host cs
      periph_cs_n = ~(sel & {NP{~cs_n}});
      // wired-or of whoever is selected
      miso        = |(sel & periph_miso);
    end
  end

endmodule

// ==== source/spi_bridge_top.sv ====
`timescale 1ns/1ps

module spi_bridge_top #(
  parameter int LOG2DELAY = 20
) (
  input  logic clk,
  input  logic rst_n,
  // host spi
  input  logic sclk,
  input  logic mosi,
  input  logic cs_n,
  input  logic special_n,
  output logic miso,
  output logic led1,
  output logic led2,
  // adc
  output logic adc_cs_n,
  output logic adc_sclk,
  output logic adc_mosi,
  input  logic adc_miso,
  // dac
  output logic dac_cs_n,
  output logic dac_sclk,
  output logic dac_sdi,
  input  logic dac_sdo,
  output logic dac_ldac,
  output logic dac_uni_bip_a,
  output logic dac_uni_bip_b,
  output logic dac_rst,
  // flash
  output logic flash_cs_n,
  output logic flash_sclk,
  output logic flash_mosi,
  input  logic flash_miso,
  // rails
  output logic rails_lp15v,
  output logic rails_lp30v,
  output logic rails_lp60v,
  output logic rails_oe
);

  logic [spi_bridge_pkg::FRAME_W-1:0]    readback;
  logic [spi_bridge_pkg::REG_W-1:0]      reg_led, reg_mux, reg_dac, reg_rails;
  logic [spi_bridge_pkg::NUM_PERIPH-1:0] periph_cs_n, periph_miso;
  logic [1:0]                            led;
  logic                                  bridge_miso;

  reg_wr_if u_wr ();    // shifter -> bank write

  ////////////////////
  // blocks

  spi_frame_shifter u_shifter (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .mosi        (mosi),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .readback    (readback),
    .bridge_miso (bridge_miso),
    .wr          (u_wr.src)
  );

  ctrl_reg_bank u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_led   (reg_led),
    .reg_mux   (reg_mux),
    .reg_dac   (reg_dac),
    .reg_rails (reg_rails),
    .readback  (readback),
    .wr        (u_wr.dst)
  );

  periph_spi_router u_router (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .reg_mux     (reg_mux),
    .periph_miso (periph_miso),
    .bridge_miso (bridge_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

  status_blinker #(.LOG2DELAY(LOG2DELAY)) u_blinker (
    .clk     (clk),
    .rst_n   (rst_n),
    .reg_led (reg_led),
    .led     (led)
  );

  ////////////////////
  // board pins

  assign periph_miso = {flash_miso, dac_sdo, adc_miso};   // adc at index 0
  assign {flash_cs_n, dac_cs_n, adc_cs_n} = periph_cs_n;

  // clock and data straight through, cs does the gating
  assign adc_sclk   = sclk;
  assign adc_mosi   = mosi;
  assign dac_sclk   = sclk;
  assign dac_sdi    = mosi;
  assign flash_sclk = sclk;
  assign flash_mosi = mosi;

  assign {dac_rst, dac_uni_bip_b, dac_uni_bip_a, dac_ldac}       = reg_dac;
  assign {rails_oe, rails_lp60v, rails_lp30v, rails_lp15v}       = reg_rails;
  assign {led1, led2} = led;    // led1 carries bit 1

endmodule

// ==== source/status_blinker.sv ====
`timescale 1ns/1ps

module status_blinker #(
  parameter int LOG2DELAY = 20    // blink period is 2**(LOG2DELAY+2) clocks
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [spi_bridge_pkg::REG_W-1:0] reg_led,
  output logic [1:0]                       led
);

  logic [LOG2DELAY+1:0] count;    // top two bits are the phase
  logic [1:0]           phase;

  assign phase = count[LOG2DELAY+1:LOG2DELAY];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count <= '0;
      led   <= 2'b00;
    end
    else
    begin
      count <= count + 1'b1;
      if (reg_led[spi_bridge_pkg::LED_MANUAL_BIT])
        led <= reg_led[1:0];                      // manual mode
      else
        led <= phase ^ (phase >> 1);              // gray, one bit per step
    end
  end

endmodule

// ==== spi_frontend/spi_frame_shifter.sv ====
`timescale 1ns/1ps

module spi_frame_shifter (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               sclk,
  input  logic                               mosi,
  input  logic                               cs_n,
  input  logic                               special_n,
  input  logic [spi_bridge_pkg::FRAME_W-1:0] readback,
  output logic                               bridge_miso,
  reg_wr_if.src                              wr
);

  localparam int CNT_W = $clog2(spi_bridge_pkg::FRAME_W) + 1;

  logic [1:0] sclk_sync;    // 2-stage synchronizers
  logic [1:0] cs_sync;
  logic [1:0] spec_sync;
  logic [1:0] mosi_sync;
  logic       sclk_q;       // previous synced value, for edges
  logic       cs_q;

  logic [spi_bridge_pkg::FRAME_W-1:0] frame;      // mosi shift-in
  logic [spi_bridge_pkg::FRAME_W-1:0] shift_out;  // readback shift-out
  logic [spi_bridge_pkg::FRAME_W-1:0] pend_word;  // frame waiting on handshake
  logic [CNT_W-1:0]                   bit_cnt;
  logic                               abort;      // special_n went high mid frame
  logic                               pend;

  logic sclk_rise, sclk_fall, cs_fall, cs_rise, frame_done, bus_free;

  ////////////////////
  // sync and edges

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_sync <= 2'b00;
      cs_sync   <= 2'b11;    // idle deselected
      spec_sync <= 2'b11;
      sclk_q    <= 1'b0;
      cs_q      <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs_n};
      spec_sync <= {spec_sync[0], special_n};
      sclk_q    <= sclk_sync[1];
      cs_q      <= cs_sync[1];
    end
  end

  // data only, sampled on sclk rise
  always_ff @(posedge clk)
    mosi_sync <= {mosi_sync[0], mosi};

  assign sclk_rise = sclk_sync[1] & ~sclk_q;
  assign sclk_fall = ~sclk_sync[1] & sclk_q;
  assign cs_fall   = ~cs_sync[1] & cs_q;
  assign cs_rise   = cs_sync[1] & ~cs_q;

  // exactly 16 bits, special_n low the whole time
  assign frame_done = cs_rise && !abort && !spec_sync[1]
                      && bit_cnt == CNT_W'(spi_bridge_pkg::FRAME_W);
  assign bus_free   = !wr.req && !wr.ack;

  ////////////////////
  // frame shifting

  always_ff @(posedge clk)
    if (sclk_rise && !cs_sync[1] && !spec_sync[1])
      frame <= {frame[spi_bridge_pkg::FRAME_W-2:0], mosi_sync[1]};  // msb first

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      bit_cnt   <= '0;
      abort     <= 1'b0;
      shift_out <= '0;
    end
    else if (cs_fall)
    begin
      bit_cnt   <= '0;
      abort     <= spec_sync[1];
      shift_out <= readback;    // led reg goes out first
    end
    else if (!cs_sync[1])
    begin
      if (spec_sync[1])
        abort <= 1'b1;
      if (sclk_rise && !spec_sync[1] && bit_cnt != '1)
        bit_cnt <= bit_cnt + 1'b1;    // saturates, long frames never match
      if (sclk_fall)
        shift_out <= shift_out << 1;
    end
  end

  assign bridge_miso = shift_out[spi_bridge_pkg::FRAME_W-1];

  ////////////////////
  // request side of handshake

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr.req <= 1'b0;
      pend   <= 1'b0;
    end
    else
    begin
      if (wr.req && wr.ack)
        wr.req <= 1'b0;    // bank took it
      if (frame_done && !bus_free)
        pend <= 1'b1;      // park until ack drops
      else if (bus_free && (frame_done || pend))
      begin
        wr.req <= 1'b1;
        pend   <= 1'b0;
      end
    end
  end

  // payload, stable from req rise until ack fall
  always_ff @(posedge clk)
  begin
    if (frame_done && !bus_free)
      pend_word <= frame;
    if (bus_free && frame_done)
      {wr.addr, wr.val} <= frame;
    else if (bus_free && pend)
      {wr.addr, wr.val} <= pend_word;
  end

endmodule

// ==== tb.f ====
common/spi_bridge_pkg.sv
common/reg_wr_if.sv
spi_frontend/spi_frame_shifter.sv
source/ctrl_reg_bank.sv
source/periph_spi_router.sv
source/status_blinker.sv
source/spi_bridge_top.sv
tests/spi_bridge_tb.sv

// ==== tests/spi_bridge_tb.sv ====
`timescale 1ns/1ps

module spi_bridge_tb;

  localparam int HALF = 8;     // sclk half period in clk cycles
  localparam int TMO  = 64;    // cycles before any wait gives up

  logic clk = 1'b0;
  logic rst_n, sclk, mosi, cs_n, special_n;
  logic adc_miso, dac_sdo, flash_miso;
  logic miso, led1, led2;
  logic adc_cs_n, adc_sclk, adc_mosi;
  logic dac_cs_n, dac_sclk, dac_sdi, dac_ldac, dac_uni_bip_a, dac_uni_bip_b, dac_rst;
  logic flash_cs_n, flash_sclk, flash_mosi;
  logic rails_lp15v, rails_lp30v, rails_lp60v, rails_oe;

  integer     seed  = 32'h9879;
  int         n_err = 0;
  int         n_tmo = 0;
  logic [3:0] m_led, m_mux, m_dac, m_rails;    // scoreboard copy of the bank

  spi_bridge_top #(.LOG2DELAY(3)) u_dut (.*);

  always #50 clk = ~clk;

  // peripherals answer with noise
  always @(posedge clk)
    {flash_miso, dac_sdo, adc_miso} <= 3'($random(seed));

  ////////////////////
  // reporting

  task automatic flag_mismatch(input string msg);
    n_err++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic count_timeout(input string what);
    n_tmo++;
    $display("timeout: %s did not happen within %0d clock cycles", what, TMO);
  endtask

  ////////////////////
  // reference model

  // set bits go in first and clear bits win
  function automatic logic [3:0] set_then_clear(input logic [3:0] cur, input logic [7:0] val);
    logic [3:0] res;
    res = cur;
    for (int i = 0; i < 4; i++)
    begin
      if (val[i])
        res[i] = 1'b1;
      if (val[i+4])
        res[i] = 1'b0;
    end
    return res;
  endfunction

  // each peripheral takes host cs when selected and is parked high otherwise
  function automatic logic [2:0] cs_expected(input logic [3:0] mux, input logic host_cs);
    logic [2:0] cs;
    for (int i = 0; i < 3; i++)
      cs[i] = mux[i] ? host_cs : 1'b1;
    return cs;
  endfunction

  task automatic model_write(input logic [15:0] word);
    case (word[15:8])
      spi_bridge_pkg::ADDR_LED:   m_led   = set_then_clear(m_led, word[7:0]);
      spi_bridge_pkg::ADDR_MUX:   m_mux   = set_then_clear(m_mux, word[7:0]);
      spi_bridge_pkg::ADDR_DAC:   m_dac   = set_then_clear(m_dac, word[7:0]);
      spi_bridge_pkg::ADDR_RAILS: m_rails = set_then_clear(m_rails, word[7:0]);
      spi_bridge_pkg::ADDR_SOFT_RST:
      begin
        m_led   = '0;
        m_mux   = '0;
        m_dac   = '0;
        m_rails = '0;
      end
      default: ;    // ignored address
    endcase
  endtask

  ////////////////////
  // continuous checks

  a_cs_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !special_n |-> {flash_cs_n, dac_cs_n, adc_cs_n} == 3'b111)
    else flag_mismatch("peripheral cs low during a bridge frame");

  a_cs_route: assert property (@(posedge clk) disable iff (!rst_n)
    special_n |-> {flash_cs_n, dac_cs_n, adc_cs_n} == cs_expected(m_mux, cs_n))
    else flag_mismatch($sformatf("cs pins wrong for mux %b", m_mux));

  a_miso_or: assert property (@(posedge clk) disable iff (!rst_n)
    special_n |-> miso == ((m_mux[0] && adc_miso) || (m_mux[1] && dac_sdo)
                           || (m_mux[2] && flash_miso)))
    else flag_mismatch($sformatf("miso is not the or of selected peripherals, mux %b", m_mux));

  // sclk and mosi reach every peripheral untouched
  a_sclk_mosi_thru: assert property (@(posedge clk) disable iff (!rst_n)
    {adc_sclk, dac_sclk, flash_sclk, adc_mosi, dac_sdi, flash_mosi}
      == {sclk, sclk, sclk, mosi, mosi, mosi})
    else flag_mismatch("sclk or mosi not passed through to the peripherals");

  // gray code moves one led at a time
  a_led_gray: assert property (@(posedge clk) disable iff (!rst_n)
    special_n && !m_led[3] |-> $countones({led1, led2} ^ $past({led1, led2})) <= 1)
    else flag_mismatch("both leds changed on one edge in blink mode");

  a_led_manual: assert property (@(posedge clk) disable iff (!rst_n)
    special_n && m_led[3] |-> {led1, led2} == m_led[1:0])
    else flag_mismatch($sformatf("leds %b%b, manual value %b", led1, led2, m_led[1:0]));

  ////////////////////
  // host side

  task automatic ticks(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic check_pins();
    assert ({dac_rst, dac_uni_bip_b, dac_uni_bip_a, dac_ldac} == m_dac)
      else flag_mismatch($sformatf("dac pins wrong, expected %b", m_dac));
    assert ({rails_oe, rails_lp60v, rails_lp30v, rails_lp15v} == m_rails)
      else flag_mismatch($sformatf("rails pins wrong, expected %b", m_rails));
  endtask

  task automatic wait_handshake();
    int t;
    for (t = 0; t < TMO && !u_dut.u_wr.ack; t++)
      @(posedge clk);
    if (!u_dut.u_wr.ack)
      count_timeout("write ack from the register bank");
    for (t = 0; t < TMO && (u_dut.u_wr.req || u_dut.u_wr.ack); t++)
      @(posedge clk);
    if (u_dut.u_wr.req || u_dut.u_wr.ack)
      count_timeout("release of the write handshake");
  endtask

  task automatic expect_no_write();
    repeat (2 * HALF)
    begin
      @(posedge clk);
      assert (!u_dut.u_wr.req) else flag_mismatch("write request after a bad frame");
    end
  endtask

  // bit-bang one frame msb first
  // glitch lifts special_n mid frame
  task automatic bridge_frame(input logic [31:0] data, input int nbits, input bit glitch);
    logic [15:0] rb;
    logic [15:0] rb_exp;
    rb_exp = {m_led, m_mux, m_dac, m_rails};    // state before this frame
    rb     = '0;
    special_n <= 1'b0;
    ticks(HALF);
    cs_n <= 1'b0;
    for (int i = nbits - 1; i >= 0; i--)
    begin
      mosi <= data[i];
      ticks(HALF);
      sclk <= 1'b1;
      rb = {rb[14:0], miso};    // bridge drives on falling edges
      if (glitch && i == nbits / 2)
      begin
        ticks(2);
        special_n <= 1'b1;
        ticks(4);
        special_n <= 1'b0;
        ticks(HALF - 6);
      end
      else
        ticks(HALF);
      sclk <= 1'b0;
    end
    ticks(HALF);
    cs_n <= 1'b1;
    mosi <= 1'b0;
    if (nbits == 16)
      assert (rb == rb_exp)
        else flag_mismatch($sformatf("readback %h, expected %h", rb, rb_exp));
    if (nbits == 16 && !glitch)
    begin
      wait_handshake();
      model_write(data[15:0]);
    end
    else
      expect_no_write();
    check_pins();
  endtask

  // pass-through traffic with the bridge idle
  task automatic passthrough_burst();
    special_n <= 1'b1;
    ticks(4);
    repeat (4)
    begin
      cs_n <= 1'b0;
      ticks(6);
      cs_n <= 1'b1;
      ticks(3);
    end
    special_n <= 1'b0;
  endtask

  task automatic wait_led_toggle();
    logic l1, l2;
    bit   c1, c2;
    l1 = led1;
    l2 = led2;
    c1 = 1'b0;
    c2 = 1'b0;
    for (int t = 0; t < TMO && !(c1 && c2); t++)
    begin
      @(posedge clk);
      c1 |= (led1 != l1);
      c2 |= (led2 != l2);
    end
    if (!(c1 && c2))
      count_timeout("toggle of both blinker leds");
  endtask

  ////////////////////
  // sequence

  initial
  begin
    logic [3:0] v;
    logic [7:0] a;
    logic [7:0] val;
    rst_n      = 1'b0;
    sclk       = 1'b0;
    mosi       = 1'b0;
    cs_n       = 1'b1;
    special_n  = 1'b1;
    adc_miso   = 1'b0;
    dac_sdo    = 1'b0;
    flash_miso = 1'b0;
    m_led      = '0;
    m_mux      = '0;
    m_dac      = '0;
    m_rails    = '0;
    ticks(16);
    rst_n <= 1'b1;
    ticks(4);

    // random set/clear writes then ignored addresses
    repeat (12)
    begin
      a   = spi_bridge_pkg::ADDR_LED + 8'($random(seed) & 3);
      val = 8'($random(seed));
      bridge_frame({16'h0, a, val}, 16, 1'b0);
    end
    bridge_frame({16'h0, 8'd6, 8'h0F}, 16, 1'b0);
    bridge_frame({16'h0, 8'd12, 8'hF0}, 16, 1'b0);

    // bad frames leave the registers alone
    bridge_frame($random(seed), 15, 1'b0);
    bridge_frame($random(seed), 17, 1'b0);
    bridge_frame({16'h0, spi_bridge_pkg::ADDR_DAC, m_dac, ~m_dac}, 16, 1'b1);

    // every mux setting with pass-through traffic
    for (int k = 0; k < 8; k++)
    begin
      v = 4'(k);
      bridge_frame({16'h0, spi_bridge_pkg::ADDR_MUX, ~v, v}, 16, 1'b0);
      passthrough_burst();
    end

    // blinker then two manual patterns
    bridge_frame({16'h0, spi_bridge_pkg::ADDR_LED, 8'hF0}, 16, 1'b0);
    special_n <= 1'b1;
    wait_led_toggle();
    bridge_frame({16'h0, spi_bridge_pkg::ADDR_LED, 8'h69}, 16, 1'b0);
    special_n <= 1'b1;
    ticks(20);
    bridge_frame({16'h0, spi_bridge_pkg::ADDR_LED, 8'h5A}, 16, 1'b0);
    special_n <= 1'b1;
    ticks(20);

    // soft reset from a non-zero state
    bridge_frame({16'h0, spi_bridge_pkg::ADDR_DAC, 8'h0F}, 16, 1'b0);
    bridge_frame({16'h0, spi_bridge_pkg::ADDR_RAILS, 8'h05}, 16, 1'b0);
    bridge_frame({16'h0, spi_bridge_pkg::ADDR_SOFT_RST, 8'h00}, 16, 1'b0);
    bridge_frame({16'h0, 8'd0, 8'h00}, 16, 1'b0);    // reads back all zero
    ticks(4);

    $display("errors: %0d failed checks, %0d timeouts", n_err, n_tmo);
    if (n_err == 0 && n_tmo == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
